// ==== include/dhcp_defs.svh ====
`ifndef DHCP_DEFS_SVH
`define DHCP_DEFS_SVH

// clock cycles in one second of the reference clock
`define DHCP_REFCLK_HZ 32'd125000000

// seconds to wait for an OFFER or an ACK
`define DHCP_TIMEOUT_SEC 4'd4

// failed attempts before the client gives up
`define DHCP_RETRIES 2'd3

// width of every lease time
`define DHCP_LEASE_BITS 24

// used when the ACK carries no lease option
`define DHCP_DEFAULT_LEASE_SEC 24'd600

`endif

// ==== rtl/dhcp_pkg.sv ====
`include "dhcp_defs.svh"

package dhcp_pkg;

  typedef logic [31:0] ipv4_t;
  typedef logic [31:0] xid_t;
  typedef logic [47:0] mac_t;
  typedef logic [`DHCP_LEASE_BITS-1:0] lease_t; // seconds

  typedef enum logic [7:0] {
    boot_request = 8'd1,
    boot_reply   = 8'd2
  } dhcp_op_t;

  // option 53 values without NAK
  typedef enum logic [7:0] {
    discover = 8'd1,
    offer    = 8'd2,
    request  = 8'd3,
    ack      = 8'd5
  } dhcp_msg_t;

  typedef enum logic [2:0] {
    idle_s,     // no lease
    discover_s, // send DISCOVER
    offer_s,    // wait for OFFER
    request_s,  // send REQUEST
    ack_s,      // wait for ACK
    upd_s,
    lease_s
  } client_state_t;

endpackage

// ==== rtl/dhcp_msg_if.sv ====
`timescale 1ns/1ps

interface dhcp_msg_if;
  logic                     val;      // one-cycle strobe
  dhcp_pkg::dhcp_op_t       op;
  dhcp_pkg::dhcp_msg_t      msg_type;
  dhcp_pkg::xid_t           xid;
  dhcp_pkg::mac_t           chaddr;
  dhcp_pkg::ipv4_t          ciaddr;
  dhcp_pkg::ipv4_t          yiaddr;   // offered / assigned address
  dhcp_pkg::ipv4_t          siaddr;
  dhcp_pkg::ipv4_t          req_ip;
  dhcp_pkg::lease_t         lease_sec;
  logic                     lease_pres;
  dhcp_pkg::lease_t         renew_sec;
  logic                     renew_pres;
  dhcp_pkg::lease_t         rebind_sec;
  logic                     rebind_pres;
  dhcp_pkg::ipv4_t          net_mask;
  logic                     mask_pres;
  dhcp_pkg::ipv4_t          router;
  logic                     router_pres;

  modport source (output val, op, msg_type, xid, chaddr, ciaddr, yiaddr, siaddr, req_ip,
    lease_sec, lease_pres, renew_sec, renew_pres, rebind_sec, rebind_pres,
    net_mask, mask_pres, router, router_pres);
  modport sink (input val, op, msg_type, xid, chaddr, ciaddr, yiaddr, siaddr, req_ip,
    lease_sec, lease_pres, renew_sec, renew_pres, rebind_sec, rebind_pres,
    net_mask, mask_pres, router, router_pres);
endinterface

// ==== rtl/dhcp_sec_tick.sv ====
`timescale 1ns/1ps
`include "dhcp_defs.svh"

module dhcp_sec_tick #(
  parameter int TICKS = `DHCP_REFCLK_HZ
) (
  input  logic clk,
  input  logic fsm_rst,
  output logic tick
);

  logic [31:0] cnt;

  always_ff @(posedge clk) begin
    if (fsm_rst) begin
      cnt  <= '0;
      tick <= 1'b0;
    end else if (cnt == TICKS - 1) begin
      cnt  <= '0; // wrap once per second
      tick <= 1'b1;
    end else begin
      cnt  <= cnt + 1'b1;
      tick <= 1'b0;
    end
  end

endmodule

// ==== rtl/dhcp_xid_lfsr.sv ====
`timescale 1ns/1ps

module dhcp_xid_lfsr (
  input  logic           clk,
  input  logic           fsm_rst,
  output dhcp_pkg::xid_t xid
);

  // taps for x^32 + x^22 + x^2 + x + 1
  localparam dhcp_pkg::xid_t POLY = 32'h8020_0003;
  localparam dhcp_pkg::xid_t SEED = 32'h1d87_2b41;

  always_ff @(posedge clk) begin
    if (fsm_rst) begin
      xid <= SEED;
    end else if (xid[0]) begin
      xid <= {1'b0, xid[31:1]} ^ POLY;
    end else begin
      xid <= {1'b0, xid[31:1]};
    end
  end

endmodule

// ==== rtl/dhcp_lease_timer.sv ====
`timescale 1ns/1ps

module dhcp_lease_timer (
  input  logic             clk,
  input  logic             fsm_rst,
  input  logic             tick,
  input  logic             lease_load,
  input  logic             lease,
  input  dhcp_pkg::lease_t lease_sec,
  input  dhcp_pkg::lease_t renew_sec,
  input  logic             renew_pres,
  input  dhcp_pkg::lease_t rebind_sec,
  input  logic             rebind_pres,
  output logic             renew,
  output logic             rebind,
  output logic             expired
);

  dhcp_pkg::lease_t cnt;
  dhcp_pkg::lease_t lease_end;
  dhcp_pkg::lease_t t1;
  dhcp_pkg::lease_t t2;

  // seconds since the last ACK
  always_ff @(posedge clk) begin
    if (lease_load) begin
      cnt       <= '0;
      lease_end <= lease_sec;
      t1        <= renew_pres ? renew_sec : lease_sec >> 1;
      t2        <= rebind_pres ? rebind_sec : lease_sec - (lease_sec >> 3); // 7/8 of lease
    end else if (lease && tick) begin
      cnt <= cnt + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (fsm_rst || lease_load || !lease) begin
      renew   <= 1'b0;
      rebind  <= 1'b0;
      expired <= 1'b0;
    end else begin
      if (cnt == t2) begin
        rebind <= 1'b1;
        renew  <= 1'b0; // rebind takes over from renew
      end else if (cnt == t1) begin
        renew <= 1'b1;
      end
      if (cnt == lease_end) expired <= 1'b1;
    end
  end

endmodule

// ==== rtl/dhcp_client_fsm.sv ====
`timescale 1ns/1ps
`include "dhcp_defs.svh"

module dhcp_client_fsm #(
  parameter dhcp_pkg::mac_t MAC_ADDR = '0
) (
  input  logic              clk,
  input  logic              fsm_rst,
  input  logic              start,
  input  dhcp_pkg::ipv4_t   pref_ip,
  input  logic              tx_done,
  input  logic              tick,
  input  dhcp_pkg::xid_t    xid_rand,
  input  logic              renew,
  input  logic              rebind,
  input  logic              expired,
  dhcp_msg_if.sink          rx,
  dhcp_msg_if.source        tx,
  output logic              ready,
  output logic              lease,
  output logic              lease_load,
  output dhcp_pkg::ipv4_t   assig_ip,
  output dhcp_pkg::ipv4_t   subnet_mask,
  output logic              subnet_mask_val,
  output dhcp_pkg::ipv4_t   router_ip,
  output logic              router_ip_val
);

  dhcp_pkg::client_state_t state;
  dhcp_pkg::xid_t          xid_q;
  dhcp_pkg::ipv4_t         offered_ip;
  dhcp_pkg::ipv4_t         server_ip;
  logic [1:0]              fail_cnt;
  logic [3:0]              tmr;
  logic                    restart;
  logic                    init;
  logic                    done;
  logic                    rebind_q;
  logic                    timeout;
  logic                    rebind_rise;
  logic                    reply_ok;

  assign timeout     = (tmr == `DHCP_TIMEOUT_SEC);
  assign rebind_rise = rebind && !rebind_q;
  assign reply_ok    = rx.val && rx.op == dhcp_pkg::boot_reply && rx.xid == xid_q &&
                       rx.chaddr == MAC_ADDR;
  // ACK taken only once our REQUEST has left
  assign lease_load  = state == dhcp_pkg::ack_s && done && reply_ok &&
                       rx.msg_type == dhcp_pkg::ack && !timeout && !rebind_rise;

  // option fields a client leaves empty
  assign tx.chaddr      = MAC_ADDR;
  assign tx.yiaddr      = '0;
  assign tx.lease_sec   = '0;
  assign tx.lease_pres  = 1'b0;
  assign tx.renew_sec   = '0;
  assign tx.renew_pres  = 1'b0;
  assign tx.rebind_sec  = '0;
  assign tx.rebind_pres = 1'b0;
  assign tx.net_mask    = '0;
  assign tx.mask_pres   = 1'b0;
  assign tx.router      = '0;
  assign tx.router_pres = 1'b0;

  always_ff @(posedge clk) begin
    if (fsm_rst) restart <= 1'b0;
    else restart <= expired || (fail_cnt == `DHCP_RETRIES);
  end

  always_ff @(posedge clk) begin
    if (fsm_rst || start) ready <= 1'b0;
    else if (lease || fail_cnt == `DHCP_RETRIES) ready <= 1'b1;
  end

  always_ff @(posedge clk) begin
    if (fsm_rst || restart) begin
      state           <= dhcp_pkg::idle_s;
      tx.val          <= 1'b0;
      lease           <= 1'b0; // assig_ip held across restart
      subnet_mask_val <= 1'b0;
      router_ip_val   <= 1'b0;
      fail_cnt        <= '0;
      tmr             <= '0;
      init            <= 1'b0;
      done            <= 1'b0;
      rebind_q        <= 1'b0;
    end else begin
      tx.val   <= 1'b0;
      rebind_q <= rebind;
      if (tick && (state == dhcp_pkg::offer_s || state == dhcp_pkg::ack_s)) tmr <= tmr + 1'b1;
      case (state)
        dhcp_pkg::idle_s: begin
          if (start || lease || (init && fail_cnt != `DHCP_RETRIES)) begin
            state <= renew ? dhcp_pkg::request_s : dhcp_pkg::discover_s;
            init  <= 1'b1;
          end
        end
        dhcp_pkg::discover_s: begin
          tmr         <= '0;
          if (!rebind) xid_q <= xid_rand; // rebind keeps the old xid
          tx.val      <= 1'b1;
          tx.op       <= dhcp_pkg::boot_request;
          tx.msg_type <= dhcp_pkg::discover;
          tx.xid      <= rebind ? xid_q : xid_rand;
          tx.ciaddr   <= '0;
          tx.siaddr   <= '0;
          tx.req_ip   <= rebind ? assig_ip : pref_ip;
          state       <= dhcp_pkg::offer_s;
        end
        dhcp_pkg::offer_s: begin
          if (timeout) begin
            state <= dhcp_pkg::idle_s;
            if (!renew) fail_cnt <= fail_cnt + 1'b1;
          end else if (reply_ok && rx.msg_type == dhcp_pkg::offer) begin
            offered_ip <= rx.yiaddr;
            server_ip  <= rx.siaddr;
            state      <= dhcp_pkg::request_s;
          end
        end
        dhcp_pkg::request_s: begin
          tmr         <= '0;
          done        <= 1'b0;
          tx.val      <= 1'b1;
          tx.op       <= dhcp_pkg::boot_request;
          tx.msg_type <= dhcp_pkg::request;
          tx.xid      <= xid_q;
          tx.ciaddr   <= renew ? assig_ip : offered_ip;
          tx.siaddr   <= server_ip;
          tx.req_ip   <= renew ? assig_ip : offered_ip;
          state       <= dhcp_pkg::ack_s;
        end
        dhcp_pkg::ack_s: begin
          if (tx_done) done <= 1'b1;
          if (timeout || rebind_rise) begin // T2 cuts a renew wait short
            state <= dhcp_pkg::idle_s;
            if (timeout && !renew) fail_cnt <= fail_cnt + 1'b1;
          end else if (lease_load) begin
            assig_ip <= rx.yiaddr;
            if (rx.mask_pres) begin
              subnet_mask     <= rx.net_mask;
              subnet_mask_val <= 1'b1;
            end
            if (rx.router_pres) begin
              router_ip     <= rx.router;
              router_ip_val <= 1'b1;
            end
            state <= dhcp_pkg::upd_s;
          end
        end
        dhcp_pkg::upd_s: begin
          done     <= 1'b0;
          fail_cnt <= '0;
          state    <= dhcp_pkg::lease_s;
        end
        dhcp_pkg::lease_s: begin
          lease <= 1'b1;
          init  <= 1'b0;
          if (rebind) state <= dhcp_pkg::discover_s;
          else if (renew) state <= dhcp_pkg::request_s;
        end
        default: state <= dhcp_pkg::idle_s;
      endcase
    end
  end

endmodule

// ==== rtl/dhcp_client.sv ====
`timescale 1ns/1ps
`include "dhcp_defs.svh"

module dhcp_client #(
  parameter dhcp_pkg::mac_t MAC_ADDR  = 48'h02_00_00_00_00_01,
  parameter int             REFCLK_HZ = `DHCP_REFCLK_HZ
) (
  input  logic             clk,
  input  logic             fsm_rst,
  input  logic             start,
  input  dhcp_pkg::ipv4_t  pref_ip,
  input  logic             rx_val,
  input  logic [7:0]       rx_op,
  input  logic [7:0]       rx_msg_type,
  input  dhcp_pkg::xid_t   rx_xid,
  input  dhcp_pkg::mac_t   rx_chaddr,
  input  dhcp_pkg::ipv4_t  rx_ciaddr,
  input  dhcp_pkg::ipv4_t  rx_yiaddr,
  input  dhcp_pkg::ipv4_t  rx_siaddr,
  input  dhcp_pkg::ipv4_t  rx_req_ip,
  input  dhcp_pkg::lease_t rx_lease_sec,
  input  logic             rx_lease_pres,
  input  dhcp_pkg::lease_t rx_renew_sec,
  input  logic             rx_renew_pres,
  input  dhcp_pkg::lease_t rx_rebind_sec,
  input  logic             rx_rebind_pres,
  input  dhcp_pkg::ipv4_t  rx_net_mask,
  input  logic             rx_mask_pres,
  input  dhcp_pkg::ipv4_t  rx_router,
  input  logic             rx_router_pres,
  input  logic             tx_done,
  output logic             tx_val,
  output logic [7:0]       tx_op,
  output logic [7:0]       tx_msg_type,
  output dhcp_pkg::xid_t   tx_xid,
  output dhcp_pkg::ipv4_t  tx_ciaddr,
  output dhcp_pkg::ipv4_t  tx_siaddr,
  output dhcp_pkg::ipv4_t  tx_req_ip,
  output logic             ready,
  output logic             lease,
  output dhcp_pkg::ipv4_t  assig_ip,
  output dhcp_pkg::ipv4_t  subnet_mask,
  output logic             subnet_mask_val,
  output dhcp_pkg::ipv4_t  router_ip,
  output logic             router_ip_val
);

  dhcp_msg_if rx ();
  dhcp_msg_if tx ();

  logic             tick;
  logic             lease_load;
  logic             renew;
  logic             rebind;
  logic             expired;
  dhcp_pkg::xid_t   xid_rand;
  dhcp_pkg::lease_t ack_lease_sec;

  assign rx.val         = rx_val;
  assign rx.op          = dhcp_pkg::dhcp_op_t'(rx_op);
  assign rx.msg_type    = dhcp_pkg::dhcp_msg_t'(rx_msg_type);
  assign rx.xid         = rx_xid;
  assign rx.chaddr      = rx_chaddr;
  assign rx.ciaddr      = rx_ciaddr;
  assign rx.yiaddr      = rx_yiaddr;
  assign rx.siaddr      = rx_siaddr;
  assign rx.req_ip      = rx_req_ip;
  assign rx.lease_sec   = rx_lease_sec;
  assign rx.lease_pres  = rx_lease_pres;
  assign rx.renew_sec   = rx_renew_sec;
  assign rx.renew_pres  = rx_renew_pres;
  assign rx.rebind_sec  = rx_rebind_sec;
  assign rx.rebind_pres = rx_rebind_pres;
  assign rx.net_mask    = rx_net_mask;
  assign rx.mask_pres   = rx_mask_pres;
  assign rx.router      = rx_router;
  assign rx.router_pres = rx_router_pres;

  assign tx_val      = tx.val;
  assign tx_op       = tx.op;
  assign tx_msg_type = tx.msg_type;
  assign tx_xid      = tx.xid;
  assign tx_ciaddr   = tx.ciaddr;
  assign tx_siaddr   = tx.siaddr;
  assign tx_req_ip   = tx.req_ip;

  // no lease option in the ACK means the default lease
  assign ack_lease_sec = rx.lease_pres ? rx.lease_sec : `DHCP_DEFAULT_LEASE_SEC;

  dhcp_sec_tick #(
    .TICKS (REFCLK_HZ)
  ) sec_tick_inst (
    .clk     (clk),
    .fsm_rst (fsm_rst),
    .tick    (tick)
  );

  dhcp_xid_lfsr xid_lfsr_inst (
    .clk     (clk),
    .fsm_rst (fsm_rst),
    .xid     (xid_rand)
  );

  dhcp_lease_timer lease_timer_inst (
    .clk         (clk),
    .fsm_rst     (fsm_rst),
    .tick        (tick),
    .lease_load  (lease_load),
    .lease       (lease),
    .lease_sec   (ack_lease_sec),
    .renew_sec   (rx.renew_sec),
    .renew_pres  (rx.renew_pres),
    .rebind_sec  (rx.rebind_sec),
    .rebind_pres (rx.rebind_pres),
    .renew       (renew),
    .rebind      (rebind),
    .expired     (expired)
  );

  dhcp_client_fsm #(
    .MAC_ADDR (MAC_ADDR)
  ) client_fsm_inst (
    .clk             (clk),
    .fsm_rst         (fsm_rst),
    .start           (start),
    .pref_ip         (pref_ip),
    .tx_done         (tx_done),
    .tick            (tick),
    .xid_rand        (xid_rand),
    .renew           (renew),
    .rebind          (rebind),
    .expired         (expired),
    .rx              (rx.sink),
    .tx              (tx.source),
    .ready           (ready),
    .lease           (lease),
    .lease_load      (lease_load),
    .assig_ip        (assig_ip),
    .subnet_mask     (subnet_mask),
    .subnet_mask_val (subnet_mask_val),
    .router_ip       (router_ip),
    .router_ip_val   (router_ip_val)
  );

endmodule

// ==== bench/dhcp_client_checker.sv ====
`timescale 1ns/1ps

module dhcp_client_checker (
  input logic            clk,
  input logic            fsm_rst,
  input logic            tx_val,
  input logic [7:0]      tx_msg_type,
  input dhcp_pkg::xid_t  tx_xid,
  input logic            ready,
  input logic            lease,
  input logic            lease_load,
  input dhcp_pkg::ipv4_t assig_ip
);

  int unsigned    err_cnt = 0;
  dhcp_pkg::xid_t disc_xid;

  // xid of the last DISCOVER on the wire
  always_ff @(posedge clk) begin
    if (tx_val && tx_msg_type == dhcp_pkg::discover) disc_xid <= tx_xid;
  end

  tx_val_pulse: assert property (@(posedge clk) disable iff (fsm_rst)
    tx_val |=> !tx_val)
    else begin
      err_cnt = err_cnt + 1;
      $error("tx_val held for more than one cycle");
    end

  assig_ip_hold: assert property (@(posedge clk) disable iff (fsm_rst)
    lease && !lease_load |=> $stable(assig_ip))
    else begin
      err_cnt = err_cnt + 1;
      $error("assig_ip changed while leased without an ACK");
    end

  request_xid: assert property (@(posedge clk) disable iff (fsm_rst)
    tx_val && tx_msg_type == dhcp_pkg::request |-> tx_xid == disc_xid)
    else begin
      err_cnt = err_cnt + 1;
      $error("REQUEST xid differs from the last DISCOVER");
    end

  quiet_in_reset: assert property (@(posedge clk)
    fsm_rst |=> !ready && !lease)
    else begin
      err_cnt = err_cnt + 1;
      $error("ready or lease set during reset");
    end

endmodule

// ==== bench/dhcp_client_tb.sv ====
`timescale 1ns/1ps
`include "dhcp_defs.svh"

module dhcp_client_tb;

  localparam dhcp_pkg::mac_t MAC = 48'h02_1a_2b_3c_4d_5e;
  localparam int SEC = 16; // cycles per second for the short bench second

  logic             clk = 1'b0;
  logic             fsm_rst;
  logic             start;
  dhcp_pkg::ipv4_t  pref_ip;
  logic             rx_val;
  logic [7:0]       rx_op;
  logic [7:0]       rx_msg_type;
  dhcp_pkg::xid_t   rx_xid;
  dhcp_pkg::mac_t   rx_chaddr;
  dhcp_pkg::ipv4_t  rx_yiaddr;
  dhcp_pkg::ipv4_t  rx_siaddr;
  dhcp_pkg::lease_t rx_lease_sec;
  dhcp_pkg::ipv4_t  rx_net_mask;
  dhcp_pkg::ipv4_t  rx_router;
  logic             tx_done;
  logic             tx_val;
  logic [7:0]       tx_op;
  logic [7:0]       tx_msg_type;
  dhcp_pkg::xid_t   tx_xid;
  dhcp_pkg::ipv4_t  tx_ciaddr;
  dhcp_pkg::ipv4_t  tx_siaddr;
  dhcp_pkg::ipv4_t  tx_req_ip;
  logic             ready;
  logic             lease;
  dhcp_pkg::ipv4_t  assig_ip;
  dhcp_pkg::ipv4_t  subnet_mask;
  logic             subnet_mask_val;
  dhcp_pkg::ipv4_t  router_ip;
  logic             router_ip_val;

  integer           seed;
  int               cyc = 0;
  int               t_tx;  // cycle of the last tx_val seen
  int               t_ack; // cycle of the last ACK sent
  dhcp_pkg::xid_t   xid_cap;
  dhcp_pkg::ipv4_t  offer_ip;
  dhcp_pkg::ipv4_t  server_ip;

  always #10 clk = ~clk;

  always @(posedge clk) cyc <= cyc + 1;

  dhcp_client #(
    .MAC_ADDR  (MAC),
    .REFCLK_HZ (SEC)
  ) uut (
    .clk (clk), .fsm_rst (fsm_rst), .start (start), .pref_ip (pref_ip),
    .rx_val (rx_val), .rx_op (rx_op), .rx_msg_type (rx_msg_type), .rx_xid (rx_xid),
    .rx_chaddr (rx_chaddr), .rx_ciaddr ('0), .rx_yiaddr (rx_yiaddr),
    .rx_siaddr (rx_siaddr), .rx_req_ip ('0), .rx_lease_sec (rx_lease_sec),
    .rx_lease_pres (1'b1), .rx_renew_sec ('0), .rx_renew_pres (1'b0),
    .rx_rebind_sec ('0), .rx_rebind_pres (1'b0), .rx_net_mask (rx_net_mask),
    .rx_mask_pres (1'b1), .rx_router (rx_router), .rx_router_pres (1'b1),
    .tx_done (tx_done), .tx_val (tx_val), .tx_op (tx_op), .tx_msg_type (tx_msg_type),
    .tx_xid (tx_xid), .tx_ciaddr (tx_ciaddr), .tx_siaddr (tx_siaddr),
    .tx_req_ip (tx_req_ip), .ready (ready), .lease (lease), .assig_ip (assig_ip),
    .subnet_mask (subnet_mask), .subnet_mask_val (subnet_mask_val),
    .router_ip (router_ip), .router_ip_val (router_ip_val)
  );

  bind dhcp_client dhcp_client_checker chk (
    .clk (clk), .fsm_rst (fsm_rst), .tx_val (tx_val), .tx_msg_type (tx_msg_type),
    .tx_xid (tx_xid), .ready (ready), .lease (lease), .lease_load (lease_load),
    .assig_ip (assig_ip)
  );

  // concurrent assertion failures stop the run at once
  always @(negedge clk) begin
    if (uut.chk.err_cnt != 0) begin
      $display("a concurrent assertion in the checker failed");
      $display("TEST FAIL");
      $fatal(1);
    end
  end

  task automatic check_value(input string name, input logic [47:0] exp,
                             input logic [47:0] act);
    assert (act === exp) else begin
      $display("Fail %s expected %0h actual %0h", name, exp, act);
      $display("TEST FAIL");
      $fatal(1);
    end
  endtask

  task automatic check_range(input string name, input int lo, input int hi, input int act);
    assert (act >= lo && act <= hi) else begin
      $display("Fail %s expected %0d to %0d actual %0d", name, lo, hi, act);
      $display("TEST FAIL");
      $fatal(1);
    end
  endtask

  task automatic stall(input string what);
    $display("timed out waiting for %s", what);
    $display("TEST FAIL");
    $fatal(1);
  endtask

  task automatic apply_reset();
    fsm_rst = 1'b1;
    repeat (10) @(negedge clk);
    fsm_rst = 1'b0;
  endtask

  task automatic pulse_start();
    start = 1'b1;
    @(negedge clk);
    start = 1'b0;
  endtask

  task automatic wait_tx(input string what, input int limit, output int cycles);
    cycles = 0;
    @(negedge clk);
    while (tx_val !== 1'b1) begin
      cycles++;
      if (cycles > limit) stall(what);
      @(negedge clk);
    end
    t_tx = cyc;
  endtask

  task automatic wait_lease(input logic level, input int limit);
    int n;
    n = 0;
    while (lease !== level) begin
      @(negedge clk);
      n++;
      if (n > limit) stall(level ? "lease to rise" : "lease to fall");
    end
  endtask

  // also counts the DISCOVERs seen on the way
  task automatic wait_ready(input int limit, output int discovers);
    int n;
    n = 0;
    discovers = 0;
    while (ready !== 1'b1) begin
      @(negedge clk);
      n++;
      if (tx_val && tx_msg_type == dhcp_pkg::discover) discovers++;
      if (n > limit) stall("ready");
    end
  endtask

  task automatic expect_quiet(input string name, input int cycles);
    repeat (cycles) begin
      @(negedge clk);
      check_value(name, 1'b0, tx_val);
    end
  endtask

  task automatic send_reply(input dhcp_pkg::dhcp_msg_t mtype, input dhcp_pkg::xid_t xid,
                            input dhcp_pkg::mac_t chaddr, input dhcp_pkg::lease_t lsec);
    rx_op        = dhcp_pkg::boot_reply;
    rx_msg_type  = mtype;
    rx_xid       = xid;
    rx_chaddr    = chaddr;
    rx_lease_sec = lsec;
    rx_val       = 1'b1;
    @(negedge clk);
    rx_val = 1'b0;
  endtask

  // server side of REQUEST and ACK
  task automatic answer_request(input string what, input int limit,
                                input dhcp_pkg::lease_t lsec);
    int n;
    wait_tx(what, limit, n);
    check_value({what, " type"}, dhcp_pkg::request, tx_msg_type);
    check_value({what, " op"}, dhcp_pkg::boot_request, tx_op);
    check_value({what, " xid"}, xid_cap, tx_xid);
    check_value({what, " ciaddr"}, offer_ip, tx_ciaddr);
    check_value({what, " req_ip"}, offer_ip, tx_req_ip);
    check_value({what, " siaddr"}, server_ip, tx_siaddr);
    tx_done = 1'b1;
    @(negedge clk);
    tx_done = 1'b0;
    t_ack = cyc;
    send_reply(dhcp_pkg::ack, xid_cap, MAC, lsec);
    wait_lease(1'b1, 10);
    check_value({what, " assig_ip"}, offer_ip, assig_ip);
  endtask

  task automatic acquire(input dhcp_pkg::lease_t lsec);
    int n;
    wait_tx("DISCOVER", 10, n);
    check_value("discover type", dhcp_pkg::discover, tx_msg_type);
    check_value("discover op", dhcp_pkg::boot_request, tx_op);
    check_value("discover req_ip", pref_ip, tx_req_ip);
    xid_cap = tx_xid;
    send_reply(dhcp_pkg::offer, xid_cap, MAC, lsec);
    answer_request("REQUEST", 10, lsec);
  endtask

  initial begin
    int n;
    int t0;
    seed         = 32'hd013;
    fsm_rst      = 1'b1;
    start        = 1'b0;
    rx_val       = 1'b0;
    rx_op        = '0;
    rx_msg_type  = '0;
    rx_xid       = '0;
    rx_chaddr    = '0;
    rx_lease_sec = '0;
    tx_done      = 1'b0;
    pref_ip      = $random(seed);
    offer_ip     = $random(seed);
    server_ip    = $random(seed);
    rx_router    = $random(seed);
    rx_net_mask  = 32'hffff_ff00;
    rx_yiaddr    = offer_ip;
    rx_siaddr    = server_ip;

    // acquisition
    apply_reset();
    pulse_start();
    acquire(24'd100);
    wait_ready(10, n);
    check_value("lease", 1'b1, lease);
    check_value("subnet_mask", rx_net_mask, subnet_mask);
    check_value("subnet_mask_val", 1'b1, subnet_mask_val);
    check_value("router_ip", rx_router, router_ip);
    check_value("router_ip_val", 1'b1, router_ip_val);

    // filtering
    apply_reset();
    pulse_start();
    wait_tx("DISCOVER", 10, n);
    xid_cap = tx_xid;
    send_reply(dhcp_pkg::offer, xid_cap ^ 32'h1, MAC, 24'd100);
    expect_quiet("tx_val after bad xid", 6);
    send_reply(dhcp_pkg::offer, xid_cap, MAC ^ 48'h1, 24'd100);
    expect_quiet("tx_val after bad chaddr", 6);
    send_reply(dhcp_pkg::offer, xid_cap, MAC, 24'd100);
    answer_request("REQUEST after filter", 10, 24'd100);

    // retries with a silent server
    apply_reset();
    pulse_start();
    wait_ready(30 * SEC, n);
    check_value("discover count", `DHCP_RETRIES, n);
    check_value("lease after retries", 1'b0, lease);
    expect_quiet("tx_val after giving up", 2 * SEC);

    // renewal with T1 at half of an 8 s lease
    apply_reset();
    pulse_start();
    acquire(24'd8);
    t0 = t_ack;
    answer_request("renewal REQUEST", 6 * SEC, 24'd8);
    check_range("renew time", 3 * SEC, 5 * SEC, t_tx - t0);
    repeat (4) begin
      @(negedge clk);
      check_value("lease after renewal ACK", 1'b1, lease);
    end

    // expiry after an unanswered renewal
    t0 = t_ack;
    wait_tx("second renewal REQUEST", 6 * SEC, n);
    check_value("second renewal type", dhcp_pkg::request, tx_msg_type);
    wait_tx("rebind DISCOVER", 5 * SEC, n);
    check_range("rebind time", 6 * SEC, 8 * SEC, t_tx - t0);
    check_value("rebind type", dhcp_pkg::discover, tx_msg_type);
    check_value("rebind req_ip", offer_ip, tx_req_ip);
    check_value("rebind xid", xid_cap, tx_xid);
    wait_lease(1'b0, 3 * SEC);
    check_range("expiry time", 7 * SEC, 9 * SEC, cyc - t0);
    check_value("assig_ip after expiry", offer_ip, assig_ip);

    repeat (4) @(negedge clk);
    if (uut.chk.err_cnt == 0) begin
      $display("TEST PASS");
      $finish;
    end else begin
      $display("TEST FAIL");
      $fatal(1);
    end
  end

endmodule

// ==== tb.f ====
+incdir+include
rtl/dhcp_pkg.sv
rtl/dhcp_msg_if.sv
rtl/dhcp_sec_tick.sv
rtl/dhcp_xid_lfsr.sv
rtl/dhcp_lease_timer.sv
rtl/dhcp_client_fsm.sv
rtl/dhcp_client.sv
bench/dhcp_client_checker.sv
bench/dhcp_client_tb.sv

// ==== Bender.yml ====
package:
  name: dhcp_client

export_include_dirs:
  - include

sources:
  - files:
      - rtl/dhcp_pkg.sv
      - rtl/dhcp_msg_if.sv
      - rtl/dhcp_sec_tick.sv
      - rtl/dhcp_xid_lfsr.sv
      - rtl/dhcp_lease_timer.sv
      - rtl/dhcp_client_fsm.sv
      - rtl/dhcp_client.sv
  - target: simulation
    files:
      - bench/dhcp_client_checker.sv
      - bench/dhcp_client_tb.sv
